// ==== decode_main.f ====
rtl/decode_pkg.sv
rtl/decode_fields.sv
rtl/decode_bank_map.sv
rtl/decode_stage_reg.sv
rtl/decode_main.sv
test/decode_checker.sv
test/tb_decode_main.sv

// ==== rtl/decode_bank_map.sv ====
// Maps r0-r15 to physical indices by mode. Needs PHY_REGS of 31 or more.
// Constant operands pass through untouched.

module decode_bank_map #(
        // Size of the physical register file.
        parameter int unsigned PHY_REGS = 32
)
(
        input  decode_pkg::arch_uop_t  i_arch_uop,
        input  decode_pkg::cpu_mode_e  i_cpu_mode,
        input  logic [31:0]            i_pc,
        output decode_pkg::issue_uop_t o_issue_uop
);

// ----------------------------------------------------------

// Banked copies of r8-r14 in FIQ, r13-r14 in the other modes.
// Everything else keeps its own number.
function automatic logic [decode_pkg::PHY_IDX_W-1:0] bank_index (
        input logic [decode_pkg::ARCH_REG_W-1:0] arch,
        input decode_pkg::cpu_mode_e             mode
);
        logic [decode_pkg::PHY_IDX_W-1:0] idx;
        logic [decode_pkg::PHY_IDX_W-1:0] base;
        logic                             banked;

        idx    = {1'b0, arch};
        base   = '0;
        banked = (arch == 4'd13) || (arch == 4'd14);

        case ( mode )
        decode_pkg::MODE_IRQ: base = 5'd23;
        decode_pkg::MODE_SVC: base = 5'd25;
        decode_pkg::MODE_ABT: base = 5'd27;
        decode_pkg::MODE_UND: base = 5'd29;
        default:              base = '0;
        endcase

        // FIQ banks a wider range, r8 lands on 16.
        if ( mode == decode_pkg::MODE_FIQ && arch >= 4'd8 && arch <= 4'd14 )
                idx = {1'b0, arch} + 5'd8;
        else if ( banked && base != '0 )
                idx = base + {4'd0, arch == 4'd14};

        return idx;
endfunction

// ----------------------------------------------------------

always_comb
begin
        o_issue_uop.cond        = i_arch_uop.cond;
        o_issue_uop.alu_op      = i_arch_uop.alu_op;
        o_issue_uop.flag_update = i_arch_uop.flag_update;
        o_issue_uop.exc         = i_arch_uop.exc;
        o_issue_uop.pc          = i_pc;

        // Destination and first source are always registers.
        o_issue_uop.rd = bank_index(i_arch_uop.rd, i_cpu_mode);
        o_issue_uop.rn = bank_index(i_arch_uop.rn, i_cpu_mode);

        // Operand 2 is translated only in its register form.
        o_issue_uop.op2 = i_arch_uop.op2;
        if ( !i_arch_uop.op2.is_immed )
                o_issue_uop.op2.value.register.idx =
                        bank_index(i_arch_uop.op2.value.register.idx[3:0], i_cpu_mode);
end

// Indices must fit the register file for any mode word.
always_comb
begin
        a_idx_range: assert final (o_issue_uop.rd < PHY_REGS &&
                                   o_issue_uop.rn < PHY_REGS &&
                                   (o_issue_uop.op2.is_immed ||
                                    o_issue_uop.op2.value.register.idx < PHY_REGS))
        else $error("decode_bank_map: physical index out of range");
end

endmodule

// ==== rtl/decode_fields.sv ====
// Combinational field split of one 32-bit instruction word.
// Only data processing (27:26 = 00) and SWI (27:24 all ones) are legal.

module decode_fields
(
        // Instruction and its valid level.
        input  logic [31:0]            i_instruction,
        input  logic                   i_instruction_valid,

        // Interrupt and abort events.
        input  logic                   i_irq,
        input  logic                   i_fiq,
        input  logic                   i_abt,

        // Decoded micro-op, architectural numbering.
        output decode_pkg::arch_uop_t  o_arch_uop
);

// ----------------------------------------------------------

logic        swi_pattern;
logic        data_proc;
logic [4:0]  rot_amount;
logic [31:0] imm_byte;
logic [63:0] imm_pair;
logic [31:0] imm_rotated;

// Format detection.
always_comb swi_pattern = &i_instruction[27:24];
always_comb data_proc   = (i_instruction[27:26] == 2'b00);

// Immediate is rotated right by twice the 4-bit field.
always_comb rot_amount  = {i_instruction[11:8], 1'b0};
always_comb imm_byte    = {24'd0, i_instruction[7:0]};

// Shifting a doubled word gives a rotate in the low half.
always_comb imm_pair    = {imm_byte, imm_byte} >> rot_amount;
always_comb imm_rotated = imm_pair[31:0];

// ----------------------------------------------------------

always_comb
begin
        // A dead slot carries the never condition.
        o_arch_uop.cond        = i_instruction_valid ? i_instruction[31:28]
                                                     : decode_pkg::COND_NV;
        o_arch_uop.alu_op      = i_instruction[24:21];
        o_arch_uop.flag_update = i_instruction[20];
        o_arch_uop.rn          = i_instruction[19:16];
        o_arch_uop.rd          = i_instruction[15:12];

        // Operand 2 through the union.
        o_arch_uop.op2.is_immed = i_instruction[25];
        if ( i_instruction[25] )
        begin
                o_arch_uop.op2.value.constant = imm_rotated;
        end
        else
        begin
                o_arch_uop.op2.value.register.zero = '0;
                o_arch_uop.op2.value.register.idx  = {1'b0, i_instruction[3:0]};
        end

        // Abort only counts with a valid instruction.
        o_arch_uop.exc.abt = i_abt && i_instruction_valid;

        // FIQ yields to abort, IRQ yields to both.
        o_arch_uop.exc.fiq = i_fiq && !o_arch_uop.exc.abt;
        o_arch_uop.exc.irq = i_irq && !i_fiq && !o_arch_uop.exc.abt;

        // SWI only noted when no event is pending.
        // Condition is checked further down the pipe.
        o_arch_uop.exc.swi = i_instruction_valid && swi_pattern &&
                             !(i_irq || i_fiq || i_abt);

        // Anything outside the two formats.
        o_arch_uop.exc.und = i_instruction_valid && !swi_pattern && !data_proc;
end

// ----------------------------------------------------------

// Events reaching the output are mutually exclusive.
always_comb
begin
        a_one_event: assert final ($onehot0({o_arch_uop.exc.irq,
                                             o_arch_uop.exc.fiq,
                                             o_arch_uop.exc.abt}))
        else $error("decode_fields: more than one of irq, fiq, abt set");
end

endmodule

// ==== rtl/decode_main.sv ====
// Decode stage top. One cycle from instruction to micro-op.
// Set PHY_REGS to 31 or more.

module decode_main #(
        parameter int unsigned PHY_REGS = 32
)
(
        input  logic                   i_clk,
        input  logic                   i_reset,

        // Instruction side.
        input  logic [31:0]            i_instruction,
        input  logic                   i_instruction_valid,
        input  logic [31:0]            i_pc,

        // Events and mode.
        input  logic                   i_irq,
        input  logic                   i_fiq,
        input  logic                   i_abt,
        input  decode_pkg::cpu_mode_e  i_cpu_mode,

        // Clear and stall levels, high to low priority.
        input  logic                   i_clear_from_writeback,
        input  logic                   i_data_stall,
        input  logic                   i_clear_from_alu,
        input  logic                   i_stall_from_issue,

        output decode_pkg::issue_uop_t o_uop_ff
);

// ----------------------------------------------------------

decode_pkg::arch_uop_t  arch_uop;
decode_pkg::issue_uop_t issue_uop;

// Field split and event priority.
decode_fields u_decode_fields (
        .i_instruction       (i_instruction),
        .i_instruction_valid (i_instruction_valid),
        .i_irq               (i_irq),
        .i_fiq               (i_fiq),
        .i_abt               (i_abt),
        .o_arch_uop          (arch_uop)
);

// Banking.
decode_bank_map #(
        .PHY_REGS (PHY_REGS)
) u_decode_bank_map (
        .i_arch_uop  (arch_uop),
        .i_cpu_mode  (i_cpu_mode),
        .i_pc        (i_pc),
        .o_issue_uop (issue_uop)
);

// The only state in the stage.
decode_stage_reg u_decode_stage_reg (
        .i_clk                  (i_clk),
        .i_reset                (i_reset),
        .i_issue_uop            (issue_uop),
        .i_clear_from_writeback (i_clear_from_writeback),
        .i_clear_from_alu       (i_clear_from_alu),
        .i_data_stall           (i_data_stall),
        .i_stall_from_issue     (i_stall_from_issue),
        .o_uop_ff               (o_uop_ff)
);

endmodule

// ==== rtl/decode_pkg.sv ====
// Shared types of the decode stage. Only data-processing and SWI formats are decoded.
// Mode values outside the listed encodings are handled as USR.

package decode_pkg;

        // ----------------------------------------------------------
        // Widths.
        // ----------------------------------------------------------

        // Architectural register number, r0 to r15.
        localparam int ARCH_REG_W = 4;

        // Physical register index after banking.
        localparam int PHY_IDX_W  = 5;

        // Condition code "never". A micro-op carrying it is dead.
        localparam logic [3:0] COND_NV = 4'b1111;

        // ----------------------------------------------------------
        // Processor modes.
        // ----------------------------------------------------------

        // Standard CPSR mode encodings.
        typedef enum logic [4:0] {
                MODE_USR = 5'b10000,
                MODE_FIQ = 5'b10001,
                MODE_IRQ = 5'b10010,
                MODE_SVC = 5'b10011,
                MODE_ABT = 5'b10111,
                MODE_UND = 5'b11011,
                MODE_SYS = 5'b11111
        } cpu_mode_e;

        // ----------------------------------------------------------
        // Operand 2.
        // ----------------------------------------------------------

        // Register view of the operand word.
        // Upper bits stay zero.
        typedef struct packed {
                logic [26:0]          zero;
                logic [PHY_IDX_W-1:0] idx;
        } reg_view_t;

        // One word, read as a constant or as a register index.
        typedef union packed {
                logic [31:0] constant;
                reg_view_t   register;
        } operand_u;

        // Selector on top. Set means the constant view is valid.
        typedef struct packed {
                logic     is_immed;
                operand_u value;
        } operand_t;

        // Exception flags, one per source.
        typedef struct packed {
                logic irq;
                logic fiq;
                logic abt;
                logic swi;
                logic und;
        } exc_t;

        // ----------------------------------------------------------
        // Micro-ops.
        // ----------------------------------------------------------

        // Fields as decoded, register numbers still architectural.
        typedef struct packed {
                logic [3:0]            cond;
                logic [3:0]            alu_op;
                logic                  flag_update;
                logic [ARCH_REG_W-1:0] rd;
                logic [ARCH_REG_W-1:0] rn;
                operand_t              op2;
                exc_t                  exc;
        } arch_uop_t;

        // Same micro-op after banking, with the PC attached.
        typedef struct packed {
                logic [3:0]           cond;
                logic [3:0]           alu_op;
                logic                 flag_update;
                logic [PHY_IDX_W-1:0] rd;
                logic [PHY_IDX_W-1:0] rn;
                operand_t             op2;
                exc_t                 exc;
                logic [31:0]          pc;
        } issue_uop_t;

endpackage

// ==== rtl/decode_stage_reg.sv ====
// Decode pipeline register. Clear beats stall. ALU clear is ignored during a data stall.
// Upstream holds its inputs while stalled.

module decode_stage_reg
(
        input  logic                   i_clk,
        input  logic                   i_reset,

        // Micro-op from the bank map.
        input  decode_pkg::issue_uop_t i_issue_uop,

        // Clear and stall levels.
        input  logic                   i_clear_from_writeback,
        input  logic                   i_clear_from_alu,
        input  logic                   i_data_stall,
        input  logic                   i_stall_from_issue,

        // Registered micro-op.
        output decode_pkg::issue_uop_t o_uop_ff
);

// ----------------------------------------------------------

logic                   clear_now;
logic                   stall_now;
decode_pkg::issue_uop_t killed_uop;

// Writeback clear always wins.
// ALU clear waits out a data stall.
always_comb clear_now = i_clear_from_writeback || (i_clear_from_alu && !i_data_stall);
always_comb stall_now = i_data_stall || i_stall_from_issue;

always_comb
begin
        // Kill keeps the payload, drops condition and events.
        killed_uop      = o_uop_ff;
        killed_uop.cond = decode_pkg::COND_NV;
        killed_uop.exc  = '0;
end

// ----------------------------------------------------------

always_ff @ ( posedge i_clk )
begin
        if ( i_reset )
        begin
                // Empty slot after reset.
                o_uop_ff      <= '0;
                o_uop_ff.cond <= decode_pkg::COND_NV;
        end
        else if ( clear_now )
        begin
                o_uop_ff <= killed_uop;
        end
        else if ( !stall_now )
        begin
                o_uop_ff <= i_issue_uop;
        end
end

// ----------------------------------------------------------

// A clear always leaves a dead slot.
a_clear_kills: assert property (@(posedge i_clk) disable iff (i_reset)
        clear_now |=> (o_uop_ff.cond == decode_pkg::COND_NV))
else $error("decode_stage_reg: slot alive after clear");

// Stall alone freezes the whole micro-op.
a_stall_holds: assert property (@(posedge i_clk) disable iff (i_reset)
        (stall_now && !clear_now) |=> $stable(o_uop_ff))
else $error("decode_stage_reg: micro-op moved during stall");

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Builds the decode stage testbench with Verilator and runs it.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
        -f decode_main.f --top-module tb_decode_main \
        -Mdir obj_dir -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -qx "Test OK" sim.log; then
        exit 0
fi
exit 1

// ==== test/decode_checker.sv ====
// Reference model of the decode stage. It samples inputs on the rising edge and
// compares o_uop_ff on the falling edge, so inputs must only move on the falling edge.

module decode_checker
(
        input  logic                   i_clk,
        input  logic                   i_reset,
        input  logic [31:0]            i_instruction,
        input  logic                   i_instruction_valid,
        input  logic [31:0]            i_pc,
        input  logic                   i_irq,
        input  logic                   i_fiq,
        input  logic                   i_abt,
        input  decode_pkg::cpu_mode_e  i_cpu_mode,
        input  logic                   i_clear_from_writeback,
        input  logic                   i_data_stall,
        input  logic                   i_clear_from_alu,
        input  logic                   i_stall_from_issue,
        input  decode_pkg::issue_uop_t i_uop_ff,
        output logic                   o_armed,
        output int                     o_checks,
        output int                     o_errors
);

decode_pkg::issue_uop_t model;
logic                   seen_reset;

initial
begin
        model      = '0;
        seen_reset = 1'b0;
        o_armed    = 1'b0;
        o_checks   = 0;
        o_errors   = 0;
end

// Banking table, r13/r14 per mode plus the wide FIQ bank.
function automatic logic [4:0] phys_index(input logic [3:0] r, input logic [4:0] mode);
        logic [4:0] p;
        p = {1'b0, r};
        if (mode == 5'b10001)
        begin
                if (r >= 4'd8 && r <= 4'd14)
                        p = {1'b0, r} + 5'd8;
        end
        else if (r == 4'd13 || r == 4'd14)
        begin
                case (mode)
                5'b10010: p = (r == 4'd13) ? 5'd23 : 5'd24;
                5'b10011: p = (r == 4'd13) ? 5'd25 : 5'd26;
                5'b10111: p = (r == 4'd13) ? 5'd27 : 5'd28;
                5'b11011: p = (r == 4'd13) ? 5'd29 : 5'd30;
                default:  p = {1'b0, r};
                endcase
        end
        return p;
endfunction

// What the stage should load from the current inputs.
function automatic decode_pkg::issue_uop_t expected_uop();
        decode_pkg::issue_uop_t u;
        logic [31:0]            w;
        logic [31:0]            imm;
        logic                   swi_word;
        logic                   abt;
        int                     rot;
        w  = i_instruction;
        u  = '0;
        u.cond        = i_instruction_valid ? w[31:28] : decode_pkg::COND_NV;
        u.alu_op      = w[24:21];
        u.flag_update = w[20];
        u.rn          = phys_index(w[19:16], i_cpu_mode);
        u.rd          = phys_index(w[15:12], i_cpu_mode);
        u.op2.is_immed = w[25];
        if (w[25])
        begin
                // Rotate right one bit at a time.
                imm = {24'd0, w[7:0]};
                rot = 2 * w[11:8];
                for (int k = 0; k < rot; k++)
                        imm = {imm[0], imm[31:1]};
                u.op2.value.constant = imm;
        end
        else
        begin
                u.op2.value.constant = {27'd0, phys_index(w[3:0], i_cpu_mode)};
        end
        swi_word  = &w[27:24];
        abt       = i_abt && i_instruction_valid;
        u.exc.abt = abt;
        u.exc.fiq = i_fiq && !abt;
        u.exc.irq = i_irq && !i_fiq && !abt;
        u.exc.swi = i_instruction_valid && swi_word && !i_irq && !i_fiq && !i_abt;
        u.exc.und = i_instruction_valid && !swi_word && (w[27:26] != 2'b00);
        u.pc      = i_pc;
        return u;
endfunction

// Prints one field mismatch. Returns 1 when the field differs.
function automatic int field_differs(input string name, input logic [31:0] exp_v,
                                     input logic [31:0] got_v);
        if (got_v !== exp_v)
        begin
                $display("CHECK FAILED at %0t: %s expected %h, got %h",
                         $time, name, exp_v, got_v);
                return 1;
        end
        return 0;
endfunction

// ----------------------------------------------------------

// Edge priority: reset, clear, stall, load.
always @(posedge i_clk)
begin
        if (i_reset)
        begin
                model      <= '0;
                model.cond <= decode_pkg::COND_NV;
                seen_reset <= 1'b1;
        end
        else if (i_clear_from_writeback || (i_clear_from_alu && !i_data_stall))
        begin
                model.cond <= decode_pkg::COND_NV;
                model.exc  <= '0;
        end
        else if (!(i_data_stall || i_stall_from_issue))
        begin
                model <= expected_uop();
        end
        if (seen_reset && !i_reset)
                o_armed <= 1'b1;
end

// Outputs are settled half a cycle after the edge.
always @(negedge i_clk)
begin
        int bad;
        bad = 0;
        if (seen_reset)
        begin
                bad = bad + field_differs("cond", model.cond, i_uop_ff.cond);
                bad = bad + field_differs("alu_op", model.alu_op, i_uop_ff.alu_op);
                bad = bad + field_differs("flag_update", model.flag_update,
                                          i_uop_ff.flag_update);
                bad = bad + field_differs("rd", model.rd, i_uop_ff.rd);
                bad = bad + field_differs("rn", model.rn, i_uop_ff.rn);
                bad = bad + field_differs("op2.is_immed", model.op2.is_immed,
                                          i_uop_ff.op2.is_immed);
                bad = bad + field_differs("op2.value", model.op2.value.constant,
                                          i_uop_ff.op2.value.constant);
                bad = bad + field_differs("exc", model.exc, i_uop_ff.exc);
                bad = bad + field_differs("pc", model.pc, i_uop_ff.pc);
                o_checks <= o_checks + 1;
                o_errors <= o_errors + bad;
        end
end

endmodule

// ==== test/tb_decode_main.sv ====
// Random testbench of the decode stage. Inputs change on the falling edge.
// All comparing happens in decode_checker.

module tb_decode_main;

localparam int CYCLES_PER_TEST = 200;
localparam int RESET_TIMEOUT   = 50;

logic                   clk;
logic                   reset;
logic [31:0]            instruction;
logic                   instruction_valid;
logic [31:0]            pc;
logic                   irq;
logic                   fiq;
logic                   abt;
decode_pkg::cpu_mode_e  cpu_mode;
logic                   clear_wb;
logic                   data_stall;
logic                   clear_alu;
logic                   stall_issue;
decode_pkg::issue_uop_t uop_ff;
logic                   armed;
int                     checks;
int                     errors;
int                     base_checks;
int                     base_errors;
int                     test_count;
int                     failed_tests;

decode_main #(.PHY_REGS(32)) uut (
        .i_clk (clk), .i_reset (reset),
        .i_instruction (instruction), .i_instruction_valid (instruction_valid),
        .i_pc (pc), .i_irq (irq), .i_fiq (fiq), .i_abt (abt), .i_cpu_mode (cpu_mode),
        .i_clear_from_writeback (clear_wb), .i_data_stall (data_stall),
        .i_clear_from_alu (clear_alu), .i_stall_from_issue (stall_issue),
        .o_uop_ff (uop_ff)
);

decode_checker u_checker (
        .i_clk (clk), .i_reset (reset),
        .i_instruction (instruction), .i_instruction_valid (instruction_valid),
        .i_pc (pc), .i_irq (irq), .i_fiq (fiq), .i_abt (abt), .i_cpu_mode (cpu_mode),
        .i_clear_from_writeback (clear_wb), .i_data_stall (data_stall),
        .i_clear_from_alu (clear_alu), .i_stall_from_issue (stall_issue),
        .i_uop_ff (uop_ff), .o_armed (armed), .o_checks (checks), .o_errors (errors)
);

initial
begin
        clk = 1'b0;
        forever #50 clk = ~clk;
end

// Hard limit on the whole run.
initial
begin
        #(100 * 20 * CYCLES_PER_TEST);
        $display("Timeout: simulation ran past its cycle budget");
        $display("Test FAILED");
        $finish;
end

// ----------------------------------------------------------

// Random data-processing word with the given I bit.
function automatic logic [31:0] dp_word(input logic imm);
        logic [31:0] w;
        w        = $urandom();
        w[27:26] = 2'b00;
        w[25]    = imm;
        return w;
endfunction

function automatic decode_pkg::cpu_mode_e legal_mode();
        case ($urandom_range(0, 6))
        0:       return decode_pkg::MODE_USR;
        1:       return decode_pkg::MODE_FIQ;
        2:       return decode_pkg::MODE_IRQ;
        3:       return decode_pkg::MODE_SVC;
        4:       return decode_pkg::MODE_ABT;
        5:       return decode_pkg::MODE_UND;
        default: return decode_pkg::MODE_SYS;
        endcase
endfunction

// Valid instruction, no events, no stall or clear.
task automatic quiet_inputs();
        instruction_valid = 1'b1;
        irq         = 1'b0;
        fiq         = 1'b0;
        abt         = 1'b0;
        clear_wb    = 1'b0;
        data_stall  = 1'b0;
        clear_alu   = 1'b0;
        stall_issue = 1'b0;
        pc          = $urandom();
endtask

// Hold reset, then wait for the checker to start with a bound.
task automatic reset_dut();
        int n;
        reset = 1'b1;
        repeat (10) @(negedge clk);
        reset = 1'b0;
        for (n = 0; n < RESET_TIMEOUT && !armed; n++)
                @(negedge clk);
        if (!armed)
        begin
                $display("Timeout: checker did not start after reset release");
                failed_tests++;
        end
endtask

// Lets the last load reach a compare, then reports the test.
task automatic end_test(input string name);
        int n_checks;
        int n_errors;
        @(posedge clk);
        @(posedge clk);
        n_checks = checks - base_checks;
        n_errors = errors - base_errors;
        test_count++;
        if (n_errors != 0 || n_checks == 0)
                failed_tests++;
        $display("test %0d %-16s %s: %0d checks, %0d errors", test_count, name,
                 (n_errors == 0 && n_checks != 0) ? "pass" : "fail", n_checks, n_errors);
        base_checks = checks;
        base_errors = errors;
endtask

// ----------------------------------------------------------

initial
begin
        logic [31:0] raw;
        void'($urandom(32'hee04f8e8));
        test_count   = 0;
        failed_tests = 0;
        base_checks  = 0;
        base_errors  = 0;
        instruction  = '0;
        cpu_mode     = decode_pkg::MODE_USR;
        reset        = 1'b1;
        quiet_inputs();
        instruction_valid = 1'b0;

        // Reset state, held by a stall so nothing loads.
        stall_issue = 1'b1;
        reset_dut();
        repeat (3) @(negedge clk);
        end_test("reset state");

        for (int i = 0; i < CYCLES_PER_TEST; i++)
        begin
                @(negedge clk);
                quiet_inputs();
                instruction = dp_word(1'b0);
                cpu_mode    = $urandom_range(0, 1) ? decode_pkg::MODE_SYS
                                                   : decode_pkg::MODE_USR;
        end
        end_test("register decode");

        for (int i = 0; i < CYCLES_PER_TEST; i++)
        begin
                @(negedge clk);
                quiet_inputs();
                instruction = dp_word(1'b1);
                cpu_mode    = legal_mode();
        end
        end_test("immediate");

        // Half the modes come from raw 5-bit values, mostly illegal.
        for (int i = 0; i < CYCLES_PER_TEST; i++)
        begin
                @(negedge clk);
                quiet_inputs();
                raw         = $urandom();
                instruction = dp_word(raw[31]);
                cpu_mode    = raw[30] ? legal_mode() : decode_pkg::cpu_mode_e'(raw[4:0]);
        end
        end_test("banking");

        for (int i = 0; i < CYCLES_PER_TEST; i++)
        begin
                @(negedge clk);
                quiet_inputs();
                instruction_valid = $urandom_range(0, 1);
                irq      = ($urandom_range(0, 3) == 0);
                fiq      = ($urandom_range(0, 3) == 0);
                abt      = ($urandom_range(0, 3) == 0);
                cpu_mode = legal_mode();
                raw      = $urandom();
                case ($urandom_range(0, 2))
                0:       instruction = dp_word(raw[0]);
                1:       instruction = {raw[31:28], 4'hf, raw[23:0]};
                default: instruction = raw;
                endcase
        end
        end_test("exceptions");

        for (int i = 0; i < CYCLES_PER_TEST; i++)
        begin
                @(negedge clk);
                quiet_inputs();
                instruction       = dp_word($urandom_range(0, 1));
                instruction_valid = $urandom_range(0, 1);
                cpu_mode    = legal_mode();
                clear_wb    = ($urandom_range(0, 5) == 0);
                clear_alu   = ($urandom_range(0, 3) == 0);
                data_stall  = ($urandom_range(0, 3) == 0);
                stall_issue = ($urandom_range(0, 3) == 0);
        end
        end_test("stall and clear");

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 test_count, failed_tests, checks, errors);
        if (failed_tests == 0 && errors == 0)
                $display("Test OK");
        else
                $display("Test FAILED");
        $finish;
end

endmodule
